//--- common/enc_pkg.sv
package enc_pkg;

    ////////////////////////////////////////////////////////////
    // ring parameters
    ////////////////////////////////////////////////////////////
    localparam int poly_n  = 16;                  // coefficients per polynomial
    localparam int q_mod   = 7681;                // coefficient modulus
    localparam int coef_w  = $clog2(q_mod);       // 13 bits
    localparam int idx_w   = $clog2(poly_n);      // 4 bits
    localparam int t_scale = (q_mod - 1) / 2;     // message scale, 3840

    typedef logic [coef_w-1:0] coef_t;
    typedef logic [idx_w-1:0]  idx_t;
    typedef logic [poly_n-1:0] msg_t;             // one bit per coefficient

    // controller walk, one pass per encryption
    typedef enum logic [2:0] {
        st_idle,
        st_load_noise,    // r0, r1, r2 in that order
        st_load_key,      // a and b side by side
        st_multiply,      // poly_n terms per output coefficient
        st_drain          // let the last result reach the output
    } enc_state_t;

    // modular add, both operands already below q
    function automatic coef_t add_mod(input coef_t x, input coef_t y);
        logic [coef_w:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= (coef_w + 1)'(q_mod))
            s = s - (coef_w + 1)'(q_mod);  // single subtract is enough
        return coef_t'(s);
    endfunction

endpackage

//--- src/enc_ctrl.sv
`timescale 1ns/10ps

module enc_ctrl
(
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    input  logic          noise_valid,
    input  logic          msg_valid,
    input  logic          key_valid,
    output logic          busy,
    output logic          noise_we,
    output logic [1:0]    noise_we_sel,   // 0 r0, 1 r1, 2 r2
    output logic          msg_we,
    output logic          key_we,
    output enc_pkg::idx_t coef_idx,
    output enc_pkg::idx_t r0_addr,
    output logic          wrap,
    output logic          mac_clear,
    output logic          mac_step,
    output logic          mac_last,
    output enc_pkg::idx_t out_idx
);

    localparam enc_pkg::idx_t last_idx = enc_pkg::idx_t'(enc_pkg::poly_n - 1);

    enc_pkg::enc_state_t state;
    enc_pkg::idx_t       i_cnt;    // output coefficient
    enc_pkg::idx_t       j_cnt;    // load index, then product term
    logic [1:0]          sel;      // which noise poly is loading

    ////////////////////////////////////////////////////////////
    // decoded strobes
    ////////////////////////////////////////////////////////////
    assign busy         = (state != enc_pkg::st_idle);
    // r2 only moves when the message is there too
    assign noise_we     = (state == enc_pkg::st_load_noise) && noise_valid &&
                          ((sel != 2'd2) || msg_valid);
    assign msg_we       = noise_we && (sel == 2'd2);
    assign noise_we_sel = sel;
    assign key_we       = (state == enc_pkg::st_load_key) && key_valid;
    assign coef_idx     = j_cnt;
    assign r0_addr      = enc_pkg::idx_t'(i_cnt - j_cnt);  // wraps mod n
    assign wrap         = (j_cnt > i_cnt);                 // x^n = -1
    assign mac_step     = (state == enc_pkg::st_multiply);
    assign mac_clear    = mac_step && (j_cnt == '0);       // first term
    assign mac_last     = mac_step && (j_cnt == last_idx);

    ////////////////////////////////////////////////////////////
    // state walk
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= enc_pkg::st_idle;
            i_cnt   <= '0;
            j_cnt   <= '0;
            sel     <= '0;
            out_idx <= '0;
        end
        else
        begin
            case (state)
                enc_pkg::st_idle:
                begin
                    if (start)
                    begin
                        state <= enc_pkg::st_load_noise;
                        i_cnt <= '0;
                        j_cnt <= '0;
                        sel   <= '0;
                    end
                end
                enc_pkg::st_load_noise:
                begin
                    if (noise_we)
                    begin
                        j_cnt <= j_cnt + 1'b1;                  // wraps to 0
                        if (j_cnt == last_idx)
                        begin
                            sel <= sel + 1'b1;
                            if (sel == 2'd2)
                            begin
                                sel   <= '0;
                                state <= enc_pkg::st_load_key;
                            end
                        end
                    end
                end
                enc_pkg::st_load_key:
                begin
                    if (key_valid)
                    begin
                        j_cnt <= j_cnt + 1'b1;
                        if (j_cnt == last_idx)
                            state <= enc_pkg::st_multiply;      // i, j both zero
                    end
                end
                enc_pkg::st_multiply:
                begin
                    j_cnt <= j_cnt + 1'b1;                      // one term per clock
                    if (j_cnt == last_idx)
                    begin
                        out_idx <= i_cnt;                       // held for combiner
                        i_cnt   <= i_cnt + 1'b1;
                        if (i_cnt == last_idx)
                            state <= enc_pkg::st_drain;
                    end
                end
                enc_pkg::st_drain:
                begin
                    j_cnt <= j_cnt + 1'b1;
                    if (j_cnt == enc_pkg::idx_t'(1))            // mac reg + output reg
                    begin
                        j_cnt <= '0;
                        state <= enc_pkg::st_idle;
                    end
                end
                default:
                    state <= enc_pkg::st_idle;
            endcase
        end
    end

endmodule

//--- src/noise_store.sv
`timescale 1ns/10ps

module noise_store
(
    input  logic           clk,
    input  logic           noise_we,
    input  logic [1:0]     noise_we_sel,
    input  logic           msg_we,      // r2 write with message present
    input  enc_pkg::idx_t  coef_idx,
    input  enc_pkg::coef_t noise_coef,
    input  enc_pkg::msg_t  message,
    input  enc_pkg::idx_t  r0_addr,
    input  enc_pkg::idx_t  out_idx,
    output enc_pkg::coef_t r0_coef,
    output enc_pkg::coef_t r1_coef,
    output enc_pkg::coef_t r2_coef
);

    enc_pkg::coef_t r0_mem [enc_pkg::poly_n];
    enc_pkg::coef_t r1_mem [enc_pkg::poly_n];
    enc_pkg::coef_t r2_mem [enc_pkg::poly_n];   // stores r2 + t*m

    enc_pkg::coef_t r2_enc;

    ////////////////////////////////////////////////////////////
    // message fold
    ////////////////////////////////////////////////////////////
    // bit one adds (q-1)/2, bit zero leaves r2 alone
    always_comb
    begin
        r2_enc = noise_coef;
        if (message[coef_idx])
            r2_enc = enc_pkg::add_mod(noise_coef, enc_pkg::coef_t'(enc_pkg::t_scale));
    end

    always_ff @(posedge clk)
    begin
        if (noise_we && (noise_we_sel == 2'd0))
            r0_mem[coef_idx] <= noise_coef;
        if (noise_we && (noise_we_sel == 2'd1))
            r1_mem[coef_idx] <= noise_coef;
        if (msg_we)
            r2_mem[coef_idx] <= r2_enc;            // leaves here encoded
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////
    assign r0_coef = r0_mem[r0_addr];   // shared by both macs
    assign r1_coef = r1_mem[out_idx];   // stable while prod_valid
    assign r2_coef = r2_mem[out_idx];

endmodule

//--- poly_mult/poly_mac.sv
`timescale 1ns/10ps

module poly_mac
(
    input  logic           clk,
    input  logic           reset,
    input  logic           key_we,
    input  enc_pkg::idx_t  coef_idx,    // write index, then term j
    input  enc_pkg::coef_t key_coef,
    input  enc_pkg::coef_t r0_coef,     // r0[(i - j) mod n]
    input  logic           wrap,
    input  logic           mac_clear,
    input  logic           mac_step,
    input  logic           mac_last,
    output logic           prod_valid,
    output enc_pkg::coef_t prod_coef
);

    enc_pkg::coef_t key_mem [enc_pkg::poly_n];    // one public key poly

    logic [2*enc_pkg::coef_w-1:0] prod_full;       // 26 bit raw product
    enc_pkg::coef_t               term;
    enc_pkg::coef_t               term_signed;
    enc_pkg::coef_t               acc;
    enc_pkg::coef_t               acc_base;
    enc_pkg::coef_t               sum;

    always_ff @(posedge clk)
    begin
        if (key_we)
            key_mem[coef_idx] <= key_coef;
    end

    ////////////////////////////////////////////////////////////
    // one schoolbook term per clock
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        prod_full = key_mem[coef_idx] * r0_coef;
        term      = enc_pkg::coef_t'(prod_full % enc_pkg::q_mod);
        // negacyclic, wrapped terms come back negated
        if (wrap && (term != '0))
            term_signed = enc_pkg::coef_t'(enc_pkg::q_mod - term);
        else
            term_signed = term;
        acc_base = mac_clear ? '0 : acc;         // fresh start at j = 0
        sum      = enc_pkg::add_mod(acc_base, term_signed);
    end

    always_ff @(posedge clk)
    begin
        if (mac_step)
            acc <= sum;
        if (mac_last)
            prod_coef <= sum;                    // finished coefficient
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            prod_valid <= 1'b0;
        else
            prod_valid <= mac_last;              // one cycle after last term
    end

endmodule

//--- src/cipher_combine.sv
`timescale 1ns/10ps

module cipher_combine
(
    input  logic           clk,
    input  logic           reset,
    input  logic           prod_valid,
    input  enc_pkg::coef_t ar0_coef,
    input  enc_pkg::coef_t br0_coef,
    input  enc_pkg::coef_t r1_coef,
    input  enc_pkg::coef_t r2_coef,    // r2 + t*m
    output logic           cipher_valid,
    output enc_pkg::coef_t cipher_c0,
    output enc_pkg::coef_t cipher_c1
);

    enc_pkg::coef_t c0_next;
    enc_pkg::coef_t c1_next;

    ////////////////////////////////////////////////////////////
    // c1 = a*r0 + r1, c0 = b*r0 + r2 + t*m
    ////////////////////////////////////////////////////////////
    assign c1_next = enc_pkg::add_mod(ar0_coef, r1_coef);
    assign c0_next = enc_pkg::add_mod(br0_coef, r2_coef);

    always_ff @(posedge clk)
    begin
        if (prod_valid)
        begin
            cipher_c0 <= c0_next;
            cipher_c1 <= c1_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            cipher_valid <= 1'b0;
        else
            cipher_valid <= prod_valid;   // single pulse per coefficient
    end

endmodule

//--- src/enc_top.sv
`timescale 1ns/10ps

module enc_top
(
    input  logic           clk,
    input  logic           reset,
    input  logic           start,          // pulse, taken in idle only
    input  logic           noise_valid,
    input  enc_pkg::coef_t noise_coef,     // r0, r1, r2 back to back
    input  logic           msg_valid,
    input  enc_pkg::msg_t  message,
    input  logic           key_valid,
    input  enc_pkg::coef_t key_a,
    input  enc_pkg::coef_t key_b,
    output logic           busy,
    output logic           cipher_valid,
    output enc_pkg::coef_t cipher_c0,
    output enc_pkg::coef_t cipher_c1
);

    ////////////////////////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////////////////////////
    logic           noise_we;
    logic [1:0]     noise_we_sel;
    logic           msg_we;
    logic           key_we;
    enc_pkg::idx_t  coef_idx;      // load index or term j
    enc_pkg::idx_t  r0_addr;       // (i - j) mod n
    logic           wrap;          // j > i, term negated
    logic           mac_clear;
    logic           mac_step;
    logic           mac_last;
    enc_pkg::idx_t  out_idx;       // index of finished coefficient
    enc_pkg::coef_t r0_coef;
    enc_pkg::coef_t r1_coef;
    enc_pkg::coef_t r2_coef;       // already holds r2 + t*m
    logic           prod_valid_a;
    logic           prod_valid_b;
    enc_pkg::coef_t ar0_coef;
    enc_pkg::coef_t br0_coef;

    enc_ctrl ctrl_i
    (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .noise_valid  (noise_valid),
        .msg_valid    (msg_valid),
        .key_valid    (key_valid),
        .busy         (busy),
        .noise_we     (noise_we),
        .noise_we_sel (noise_we_sel),
        .msg_we       (msg_we),
        .key_we       (key_we),
        .coef_idx     (coef_idx),
        .r0_addr      (r0_addr),
        .wrap         (wrap),
        .mac_clear    (mac_clear),
        .mac_step     (mac_step),
        .mac_last     (mac_last),
        .out_idx      (out_idx)
    );

    noise_store noise_i
    (
        .clk          (clk),
        .noise_we     (noise_we),
        .noise_we_sel (noise_we_sel),
        .msg_we       (msg_we),
        .coef_idx     (coef_idx),
        .noise_coef   (noise_coef),
        .message      (message),
        .r0_addr      (r0_addr),
        .out_idx      (out_idx),
        .r0_coef      (r0_coef),
        .r1_coef      (r1_coef),
        .r2_coef      (r2_coef)
    );

    // a * r0 feeds c1
    poly_mac mac_a
    (
        .clk        (clk),
        .reset      (reset),
        .key_we     (key_we),
        .coef_idx   (coef_idx),
        .key_coef   (key_a),
        .r0_coef    (r0_coef),
        .wrap       (wrap),
        .mac_clear  (mac_clear),
        .mac_step   (mac_step),
        .mac_last   (mac_last),
        .prod_valid (prod_valid_a),
        .prod_coef  (ar0_coef)
    );

    // b * r0 feeds c0
    poly_mac mac_b
    (
        .clk        (clk),
        .reset      (reset),
        .key_we     (key_we),
        .coef_idx   (coef_idx),
        .key_coef   (key_b),
        .r0_coef    (r0_coef),
        .wrap       (wrap),
        .mac_clear  (mac_clear),
        .mac_step   (mac_step),
        .mac_last   (mac_last),
        .prod_valid (prod_valid_b),
        .prod_coef  (br0_coef)
    );

    cipher_combine combine_i
    (
        .clk          (clk),
        .reset        (reset),
        .prod_valid   (prod_valid_a & prod_valid_b),  // always together
        .ar0_coef     (ar0_coef),
        .br0_coef     (br0_coef),
        .r1_coef      (r1_coef),
        .r2_coef      (r2_coef),
        .cipher_valid (cipher_valid),
        .cipher_c0    (cipher_c0),
        .cipher_c1    (cipher_c1)
    );

endmodule

//--- test/enc_assert.sv
`timescale 1ns/10ps

module enc_assert
(
    input logic                clk,
    input logic                reset,
    input logic                start,
    input logic                busy,
    input logic                cipher_valid,
    input enc_pkg::coef_t      cipher_c0,
    input enc_pkg::coef_t      cipher_c1,
    input enc_pkg::enc_state_t ctrl_state   // controller state, seen from the top
);

    ////////////////////////////////////////////////////////////
    // output stream
    ////////////////////////////////////////////////////////////
    valid_in_run: assert property (@(posedge clk) disable iff (reset)
        cipher_valid |-> busy)
        else $error("cipher_valid seen while not busy");

    // both halves reduced below q
    coef_in_range: assert property (@(posedge clk) disable iff (reset)
        cipher_valid |-> (cipher_c0 < enc_pkg::coef_t'(enc_pkg::q_mod)) &&
                         (cipher_c1 < enc_pkg::coef_t'(enc_pkg::q_mod)))
        else $error("cipher coefficient not below q");

    // a start inside a run never sends the walk back to noise loading
    start_ignored: assert property (@(posedge clk) disable iff (reset)
        (busy && start) |=> (ctrl_state != enc_pkg::st_load_noise) ||
                            ($past(ctrl_state) == enc_pkg::st_load_noise))
        else $error("start during a run restarted the controller");

endmodule

bind enc_top enc_assert assert_i
(
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .busy         (busy),
    .cipher_valid (cipher_valid),
    .cipher_c0    (cipher_c0),
    .cipher_c1    (cipher_c1),
    .ctrl_state   (ctrl_i.state)
);

//--- test/enc_tb.sv
`timescale 1ns/10ps

module enc_tb;

    localparam int seed         = 32'h18a14505;
    localparam int run_timeout  = 2000;   // cycles from last key to last pulse
    localparam int idle_timeout = 50;

    logic           clk = 1'b0;
    logic           reset;
    logic           start;
    logic           noise_valid;
    enc_pkg::coef_t noise_coef;
    logic           msg_valid;
    enc_pkg::msg_t  message;
    logic           key_valid;
    enc_pkg::coef_t key_a;
    enc_pkg::coef_t key_b;
    logic           busy;
    logic           cipher_valid;
    enc_pkg::coef_t cipher_c0;
    enc_pkg::coef_t cipher_c1;

    // vectors for one run
    enc_pkg::coef_t r0_v [enc_pkg::poly_n];
    enc_pkg::coef_t r1_v [enc_pkg::poly_n];
    enc_pkg::coef_t r2_v [enc_pkg::poly_n];
    enc_pkg::coef_t a_v [enc_pkg::poly_n];
    enc_pkg::coef_t b_v [enc_pkg::poly_n];
    enc_pkg::msg_t  msg_v;
    enc_pkg::coef_t exp_c0 [enc_pkg::poly_n];
    enc_pkg::coef_t exp_c1 [enc_pkg::poly_n];
    enc_pkg::coef_t got_c0 [enc_pkg::poly_n];
    enc_pkg::coef_t got_c1 [enc_pkg::poly_n];

    int checks;
    int errors;
    int test_base;    // error count when the test began

    enc_top enc_top_i
    (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .noise_valid  (noise_valid),
        .noise_coef   (noise_coef),
        .msg_valid    (msg_valid),
        .message      (message),
        .key_valid    (key_valid),
        .key_a        (key_a),
        .key_b        (key_b),
        .busy         (busy),
        .cipher_valid (cipher_valid),
        .cipher_c0    (cipher_c0),
        .cipher_c1    (cipher_c1)
    );

    always #4 clk = ~clk;   // 8 ns

    // inputs change and outputs are read 1 ns past the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_coef(input string name, input enc_pkg::coef_t got,
                              input enc_pkg::coef_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_base)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_base);
    endtask

    ////////////////////////////////////////////////////////////
    // vectors and reference model
    ////////////////////////////////////////////////////////////
    function automatic enc_pkg::coef_t rand_coef();
        return enc_pkg::coef_t'($urandom % enc_pkg::q_mod);
    endfunction

    task automatic fill_vectors(input bit rand_fill);
        for (int k = 0; k < enc_pkg::poly_n; k++)
        begin
            r0_v[k] = rand_fill ? rand_coef() : '0;
            r1_v[k] = rand_fill ? rand_coef() : '0;
            r2_v[k] = rand_fill ? rand_coef() : '0;
            a_v[k]  = rand_coef();    // keys always random
            b_v[k]  = rand_coef();
        end
        msg_v = rand_fill ? enc_pkg::msg_t'($urandom) : '0;
    endtask

    // schoolbook negacyclic product with x^n = -1
    task automatic model_cipher();
        int k;
        int ta;
        int tb;
        int acc_a;
        int acc_b;
        for (int i = 0; i < enc_pkg::poly_n; i++)
        begin
            acc_a = 0;
            acc_b = 0;
            for (int j = 0; j < enc_pkg::poly_n; j++)
            begin
                k  = (i - j + enc_pkg::poly_n) % enc_pkg::poly_n;
                ta = (int'(a_v[j]) * int'(r0_v[k])) % enc_pkg::q_mod;
                tb = (int'(b_v[j]) * int'(r0_v[k])) % enc_pkg::q_mod;
                if (j > i)   // wrapped term is subtracted
                begin
                    ta = enc_pkg::q_mod - ta;
                    tb = enc_pkg::q_mod - tb;
                end
                acc_a = (acc_a + ta) % enc_pkg::q_mod;
                acc_b = (acc_b + tb) % enc_pkg::q_mod;
            end
            exp_c1[i] = enc_pkg::coef_t'((acc_a + int'(r1_v[i])) % enc_pkg::q_mod);
            exp_c0[i] = enc_pkg::coef_t'((acc_b + int'(r2_v[i]) +
                        (msg_v[i] ? enc_pkg::t_scale : 0)) % enc_pkg::q_mod);
        end
    endtask

    function automatic enc_pkg::coef_t noise_word(input int k);
        if (k < enc_pkg::poly_n)
            return r0_v[k];
        if (k < 2 * enc_pkg::poly_n)
            return r1_v[k - enc_pkg::poly_n];
        return r2_v[k - 2 * enc_pkg::poly_n];
    endfunction

    ////////////////////////////////////////////////////////////
    // one full encryption
    ////////////////////////////////////////////////////////////
    task automatic run_encrypt(input bit gaps, input bit mid_start);
        int waited;
        int pulses;
        int since_last;
        waited = 0;
        while (busy && waited < idle_timeout)
        begin
            tick();
            waited++;
        end
        if (busy)
        begin
            errors++;
            $display("timeout: core still busy before start");
            return;
        end
        message = enc_pkg::msg_t'($urandom);   // only read on r2 writes
        start   = 1'b1;
        tick();
        start   = 1'b0;
        for (int k = 0; k < 3 * enc_pkg::poly_n; k++)
        begin
            repeat (gaps ? $urandom % 3 : 0)   // idle or r2 stalled on message
            begin
                noise_valid = (k >= 2 * enc_pkg::poly_n) ? 1'($urandom) : 1'b0;
                noise_coef  = rand_coef();
                msg_valid   = 1'b0;
                message     = enc_pkg::msg_t'($urandom);
                tick();
            end
            noise_valid = 1'b1;
            noise_coef  = noise_word(k);
            msg_valid   = (k >= 2 * enc_pkg::poly_n);
            message     = (k >= 2 * enc_pkg::poly_n) ? msg_v : enc_pkg::msg_t'($urandom);
            tick();
        end
        noise_valid = 1'b0;
        msg_valid   = 1'b0;
        message     = enc_pkg::msg_t'($urandom);
        for (int k = 0; k < enc_pkg::poly_n; k++)
        begin
            repeat (gaps ? $urandom % 3 : 0)
            begin
                key_valid = 1'b0;
                tick();
            end
            key_valid = 1'b1;
            key_a     = a_v[k];
            key_b     = b_v[k];
            tick();
        end
        key_valid  = 1'b0;
        pulses     = 0;
        waited     = 0;
        since_last = 0;
        while (pulses < enc_pkg::poly_n && waited < run_timeout)
        begin
            start = mid_start && (waited == 20);   // lands in st_multiply
            tick();
            waited++;
            since_last++;
            if (cipher_valid)
            begin
                got_c0[pulses] = cipher_c0;
                got_c1[pulses] = cipher_c1;
                if (pulses > 0)
                    check_bit("pulse spacing", since_last == enc_pkg::poly_n, 1'b1);
                since_last = 0;
                pulses++;
            end
        end
        start = 1'b0;
        if (pulses < enc_pkg::poly_n)
        begin
            errors++;
            $display("timeout: only %0d of %0d cipher pulses arrived", pulses, enc_pkg::poly_n);
            return;
        end
        tick();
        check_bit("busy", busy, 1'b0);   // drops right after the last pulse
        for (int i = 0; i < enc_pkg::poly_n; i++)
        begin
            check_coef($sformatf("cipher_c0[%0d]", i), got_c0[i], exp_c0[i]);
            check_coef($sformatf("cipher_c1[%0d]", i), got_c1[i], exp_c1[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_idle();
        test_base = errors;
        for (int n = 0; n < 20; n++)
        begin
            check_bit("busy", busy, 1'b0);
            check_bit("cipher_valid", cipher_valid, 1'b0);
            tick();
        end
        finish_test("reset_idle");
    endtask

    task automatic test_message_only();
        test_base = errors;
        fill_vectors(1'b0);
        msg_v = enc_pkg::msg_t'($urandom);
        for (int i = 0; i < enc_pkg::poly_n; i++)
        begin
            exp_c1[i] = '0;
            exp_c0[i] = msg_v[i] ? enc_pkg::coef_t'(enc_pkg::t_scale) : '0;
        end
        run_encrypt(1'b0, 1'b0);
        finish_test("message_only");
    endtask

    task automatic test_unit_r0();
        test_base = errors;
        fill_vectors(1'b1);
        for (int k = 0; k < enc_pkg::poly_n; k++)
            r0_v[k] = (k == 0) ? enc_pkg::coef_t'(1) : '0;
        for (int i = 0; i < enc_pkg::poly_n; i++)
        begin
            exp_c1[i] = enc_pkg::coef_t'((int'(a_v[i]) + int'(r1_v[i])) % enc_pkg::q_mod);
            exp_c0[i] = enc_pkg::coef_t'((int'(b_v[i]) + int'(r2_v[i]) +
                        (msg_v[i] ? enc_pkg::t_scale : 0)) % enc_pkg::q_mod);
        end
        run_encrypt(1'b0, 1'b0);
        finish_test("unit_r0");
    endtask

    task automatic test_wrap();
        test_base = errors;
        fill_vectors(1'b0);
        r0_v[1] = enc_pkg::coef_t'(1);   // multiply by x
        for (int i = 1; i < enc_pkg::poly_n; i++)
        begin
            exp_c1[i] = a_v[i - 1];
            exp_c0[i] = b_v[i - 1];
        end
        // top coefficient comes around negated
        exp_c1[0] = enc_pkg::coef_t'((enc_pkg::q_mod - int'(a_v[enc_pkg::poly_n - 1]))
                    % enc_pkg::q_mod);
        exp_c0[0] = enc_pkg::coef_t'((enc_pkg::q_mod - int'(b_v[enc_pkg::poly_n - 1]))
                    % enc_pkg::q_mod);
        run_encrypt(1'b0, 1'b0);
        finish_test("wrap");
    endtask

    task automatic test_random_gaps();
        test_base = errors;
        fill_vectors(1'b1);
        model_cipher();
        run_encrypt(1'b1, 1'b1);
        finish_test("random_gaps");
    endtask

    task automatic test_back_to_back();
        test_base = errors;
        for (int n = 0; n < 2; n++)
        begin
            fill_vectors(1'b1);
            model_cipher();
            run_encrypt(1'b0, 1'b0);   // next start as soon as busy drops
        end
        finish_test("back_to_back");
    endtask

    initial
    begin
        void'($urandom(seed));
        reset       = 1'b1;
        start       = 1'b0;
        noise_valid = 1'b0;
        noise_coef  = '0;
        msg_valid   = 1'b0;
        message     = '0;
        key_valid   = 1'b0;
        key_a       = '0;
        key_b       = '0;
        checks      = 0;
        errors      = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_idle();
        test_message_only();
        test_unit_r0();
        test_wrap();
        test_random_gaps();
        test_back_to_back();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- rlwe_enc.f
common/enc_pkg.sv
src/enc_ctrl.sv
src/noise_store.sv
poly_mult/poly_mac.sv
src/cipher_combine.sv
src/enc_top.sv
test/enc_assert.sv
test/enc_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = -sv --timing --assert
TOP      = enc_tb
FILELIST = rlwe_enc.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
